//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_FLAGS  ?= --binary --timing -j 0
TOP        ?= decode_tb
FILELIST   ?= rv_decode.f
OBJDIR     ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# pass or fail comes from the simulation output, no log is kept
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJDIR)

//--- include/decode_ref.svh
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// expected control bundle for one instruction
function automatic rv_ctrl_pkg::ctrl_t ref_ctrl(input logic [6:0] opcode,
                                                input logic [2:0] funct3,
                                                input logic       funct7_5);
  rv_ctrl_pkg::ctrl_t c;
  c = '0;
  case (opcode)
    rv_isa_pkg::op_lui: begin
      c.write_reg_en = 1'b1;
      c.result_sel   = rv_ctrl_pkg::res_imm;
      c.imm_sel      = rv_ctrl_pkg::imm_u;
    end
    rv_isa_pkg::op_auipc: begin
      c.write_reg_en = 1'b1;
      c.alu_src_pc   = 1'b1;
      c.alu_src_imm  = 1'b1;
      c.imm_sel      = rv_ctrl_pkg::imm_u;
    end
    rv_isa_pkg::op_jal: begin
      c.jump         = 1'b1;
      c.write_reg_en = 1'b1;
      c.alu_src_pc   = 1'b1;
      c.alu_src_imm  = 1'b1;
      c.result_sel   = rv_ctrl_pkg::res_pc4;
      c.imm_sel      = rv_ctrl_pkg::imm_j;
    end
    rv_isa_pkg::op_jalr: begin
      c.jump         = 1'b1;
      c.write_reg_en = 1'b1;
      c.use_rs1      = 1'b1;
      c.alu_src_imm  = 1'b1;
      c.result_sel   = rv_ctrl_pkg::res_pc4;
    end
    rv_isa_pkg::op_branch: begin
      c.branch     = 1'b1;
      c.use_rs1    = 1'b1;
      c.use_rs2    = 1'b1;
      c.complement = 1'b1;
      c.imm_sel    = rv_ctrl_pkg::imm_b;
    end
    rv_isa_pkg::op_load: begin
      c.d_mem_r      = 1'b1;
      c.write_reg_en = 1'b1;
      c.mem_to_reg   = 1'b1;
      c.use_rs1      = 1'b1;
      c.alu_src_imm  = 1'b1;
    end
    rv_isa_pkg::op_store: begin
      c.d_mem_w     = 1'b1;
      c.use_rs1     = 1'b1;
      c.use_rs2     = 1'b1;
      c.alu_src_imm = 1'b1;
      c.imm_sel     = rv_ctrl_pkg::imm_s;
    end
    rv_isa_pkg::op_imm: begin
      c.write_reg_en = 1'b1;
      c.use_rs1      = 1'b1;
      c.alu_src_imm  = 1'b1;
      c.alu_op       = rv_ctrl_pkg::alu_op_e'(funct3);
    end
    rv_isa_pkg::op_reg: begin
      c.write_reg_en = 1'b1;
      c.use_rs1      = 1'b1;
      c.use_rs2      = 1'b1;
      c.alu_op       = rv_ctrl_pkg::alu_op_e'(funct3);
      c.complement   = (funct3 == 3'b000) & funct7_5;
    end
    default: c = '0;
  endcase
  return c;
endfunction

// expected immediate laid out per format
function automatic logic [31:0] ref_imm(input logic [31:0] ins,
                                        input rv_ctrl_pkg::imm_sel_e sel);
  logic [31:0] v;
  case (sel)
    rv_ctrl_pkg::imm_s: v = {{21{ins[31]}}, ins[30:25], ins[11:7]};
    rv_ctrl_pkg::imm_b: v = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    rv_ctrl_pkg::imm_u: v = {ins[31:12], 12'h000};
    rv_ctrl_pkg::imm_j: v = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    default:            v = {{21{ins[31]}}, ins[30:20]};
  endcase
  return v;
endfunction

// expected hazard flag with the pipe levels returned in pc
function automatic logic ref_hazard(input logic use_rs1,
                                    input logic use_rs2,
                                    input logic mem_read_ex,
                                    input logic [4:0] rd_ex,
                                    input logic [4:0] rs1,
                                    input logic [4:0] rs2,
                                    input logic branch_jump,
                                    output rv_ctrl_pkg::pipe_ctrl_t pc);
  logic h;
  h  = mem_read_ex && (rd_ex != 5'd0) &&
       ((use_rs1 && rd_ex == rs1) || (use_rs2 && rd_ex == rs2));
  pc = '0;
  if (branch_jump) begin
    pc.reset_if_reg = 1'b1;
    pc.reset_id_reg = 1'b1;
  end else if (h) begin
    pc.hold_if_reg  = 1'b1;
    pc.reset_id_reg = 1'b1;
  end
  return h;
endfunction

`endif

//--- bench/decode_tb.sv
`default_nettype none

module decode_tb;

  `include "decode_ref.svh"

  localparam int n_writes   = 200;
  localparam int n_ctrl     = 300;
  localparam int n_imm      = 40;   // per immediate format
  localparam int n_hazard   = 300;
  localparam int n_flush    = 100;
  localparam int run_len    = 2 * 4 + 31 + 33 + 2 * n_writes + n_ctrl + 5 * n_imm +
                              n_hazard + n_flush;
  localparam int max_cycles = 2 * run_len;

  logic        clk;
  logic        reset;
  logic [31:0] instruction;
  logic [31:0] data_in;
  logic        wb_write_en;
  logic [4:0]  wb_write_addr;
  logic        mem_read_ex;
  logic [4:0]  reg_write_address_ex;
  logic        branch_jump_signal;

  rv_ctrl_pkg::ctrl_t      ctrl;
  logic [2:0]              fun_3;
  logic                    rotate_signal;
  logic [4:0]              wr_addr;
  logic [4:0]              rd_addr_1;
  logic [4:0]              rd_addr_2;
  logic [31:0]             data_1;
  logic [31:0]             data_2;
  logic [31:0]             imm;
  logic                    hazard_detect_signal;
  rv_ctrl_pkg::pipe_ctrl_t pipe_ctrl;

  logic [31:0] shadow [32];  // expected register contents
  logic        check_en;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          cycles = 0;

  instruction_decode_unit u_dut (
    .clk                                   (clk),
    .reset                                 (reset),
    .instruction                           (instruction),
    .data_in                               (data_in),
    .wb_write_en                           (wb_write_en),
    .wb_write_addr                         (wb_write_addr),
    .mem_read_ex                           (mem_read_ex),
    .reg_write_address_ex                  (reg_write_address_ex),
    .branch_jump_signal                    (branch_jump_signal),
    .ctrl                                  (ctrl),
    .fun_3                                 (fun_3),
    .rotate_signal                         (rotate_signal),
    .write_address_for_current_instruction (wr_addr),
    .reg_read_address_1                    (rd_addr_1),
    .reg_read_address_2                    (rd_addr_2),
    .data_1                                (data_1),
    .data_2                                (data_2),
    .imm                                   (imm),
    .hazard_detect_signal                  (hazard_detect_signal),
    .pipe_ctrl                             (pipe_ctrl)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name,
                             input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERR t=%0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  // sample just before the rising edge
  always @(negedge clk) begin : compare_outputs
    rv_ctrl_pkg::ctrl_t      exp_ctrl;
    rv_ctrl_pkg::pipe_ctrl_t exp_pipe;
    logic                    exp_hazard;
    #4;
    if (check_en) begin
      exp_ctrl   = ref_ctrl(instruction[6:0], instruction[14:12], instruction[30]);
      exp_hazard = ref_hazard(exp_ctrl.use_rs1, exp_ctrl.use_rs2, mem_read_ex,
                              reg_write_address_ex, instruction[19:15], instruction[24:20],
                              branch_jump_signal, exp_pipe);
      check_value("ctrl", 32'(exp_ctrl), 32'(ctrl));
      check_value("fun_3", 32'(instruction[14:12]), 32'(fun_3));
      check_value("rotate_signal", 32'(instruction[30]), 32'(rotate_signal));
      check_value("write_address", 32'(instruction[11:7]), 32'(wr_addr));
      check_value("reg_read_address_1", 32'(instruction[19:15]), 32'(rd_addr_1));
      check_value("reg_read_address_2", 32'(instruction[24:20]), 32'(rd_addr_2));
      check_value("imm", ref_imm(instruction, exp_ctrl.imm_sel), imm);
      check_value("data_1", shadow[instruction[19:15]], data_1);
      check_value("data_2", shadow[instruction[24:20]], data_2);
      check_value("hazard_detect_signal", 32'(exp_hazard), 32'(hazard_detect_signal));
      check_value("pipe_ctrl", 32'(exp_pipe), 32'(pipe_ctrl));
      if (instruction[19:15] == 5'd0) begin
        check_value("data_1 of x0", 32'd0, data_1);
      end
      if (branch_jump_signal) begin
        check_value("pipe_ctrl on flush", 32'h3, 32'(pipe_ctrl));  // both resets and no hold
      end
    end
  end

  function automatic logic [6:0] pick_opcode(input int k);
    case (k)
      0:       return rv_isa_pkg::op_lui;
      1:       return rv_isa_pkg::op_auipc;
      2:       return rv_isa_pkg::op_jal;
      3:       return rv_isa_pkg::op_jalr;
      4:       return rv_isa_pkg::op_branch;
      5:       return rv_isa_pkg::op_load;
      6:       return rv_isa_pkg::op_store;
      7:       return rv_isa_pkg::op_imm;
      default: return rv_isa_pkg::op_reg;
    endcase
  endfunction

  // opcode that uses immediate format fmt (i, s, b, u, j)
  function automatic logic [6:0] format_opcode(input int fmt, input int alt);
    case (fmt)
      0:       return (alt % 3 == 0) ? rv_isa_pkg::op_imm :
                      (alt % 3 == 1) ? rv_isa_pkg::op_load : rv_isa_pkg::op_jalr;
      1:       return rv_isa_pkg::op_store;
      2:       return rv_isa_pkg::op_branch;
      3:       return (alt % 4 < 2) ? rv_isa_pkg::op_lui : rv_isa_pkg::op_auipc;
      default: return rv_isa_pkg::op_jal;
    endcase
  endfunction

  function automatic logic [31:0] random_instr(input logic [6:0] opcode);
    logic [31:0] r;
    r = $urandom();
    return {r[31:7], opcode};
  endfunction

  function automatic logic [31:0] build_reg_instr(input logic [4:0] rs2,
                                                  input logic [4:0] rs1,
                                                  input logic [4:0] rd);
    return {7'b0000000, rs2, rs1, 3'b000, rd, rv_isa_pkg::op_reg};
  endfunction

  // waits out the last compare of the test before reporting
  task automatic report_test(input string name, input int errs_before);
    @(negedge clk);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  initial begin
    int errs_before;
    clk                  = 1'b0;
    reset                = 1'b1;
    instruction          = 32'h0000_0013;  // addi x0, x0, 0
    data_in              = 32'h0;
    wb_write_en          = 1'b0;
    wb_write_addr        = 5'd0;
    mem_read_ex          = 1'b0;
    reg_write_address_ex = 5'd0;
    branch_jump_signal   = 1'b0;
    check_en             = 1'b0;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = 32'h0;
    end
    void'($urandom(32'h9312));

    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // fill x1 to x31 and reset again so the clear can be seen
    for (int i = 1; i < 32; i++) begin
      wb_write_en   = 1'b1;
      wb_write_addr = 5'(i);
      data_in       = $urandom() | 32'h1;  // never zero
      @(negedge clk);
    end
    wb_write_en = 1'b0;
    reset       = 1'b1;
    repeat (4) @(negedge clk);
    reset    = 1'b0;
    check_en = 1'b1;

    errs_before = errors;  // every register reads zero after reset
    for (int i = 0; i < 32; i++) begin
      @(negedge clk);
      instruction = build_reg_instr(5'(31 - i), 5'(i), 5'd1);
    end
    report_test("reset read", errs_before);

    errs_before = errors;
    for (int i = 0; i < n_writes; i++) begin
      @(negedge clk);
      wb_write_en   = 1'b1;
      wb_write_addr = (i % 8 == 0) ? 5'd0 : 5'($urandom_range(1, 31));
      data_in       = $urandom();
      instruction   = build_reg_instr(5'($urandom_range(0, 31)), wb_write_addr, 5'd2);
      @(posedge clk);
      if (wb_write_addr != 5'd0) begin
        shadow[wb_write_addr] = data_in;
      end
      @(negedge clk);
      wb_write_en = 1'b0;  // read-back cycle
    end
    report_test("register write and read", errs_before);

    errs_before = errors;
    for (int i = 0; i < n_ctrl; i++) begin
      @(negedge clk);
      if (i % 10 == 9) begin
        instruction = random_instr(7'($urandom()));  // mostly unknown opcodes
      end else begin
        instruction = random_instr(pick_opcode($urandom_range(0, 8)));
      end
    end
    report_test("control decode", errs_before);

    errs_before = errors;
    for (int fmt = 0; fmt < 5; fmt++) begin
      for (int i = 0; i < n_imm; i++) begin
        @(negedge clk);
        instruction = random_instr(format_opcode(fmt, i));
        instruction[31] = (i % 2 == 1);  // negative every other time
      end
    end
    report_test("immediates", errs_before);

    errs_before = errors;
    for (int i = 0; i < n_hazard; i++) begin
      @(negedge clk);
      instruction          = random_instr(pick_opcode($urandom_range(0, 8)));
      instruction[19:15]   = 5'($urandom_range(0, 3));  // small range so matches occur
      instruction[24:20]   = 5'($urandom_range(0, 3));
      reg_write_address_ex = 5'($urandom_range(0, 3));
      mem_read_ex          = 1'($urandom_range(0, 1));
    end
    report_test("load-use hazard", errs_before);

    errs_before = errors;
    for (int i = 0; i < n_flush; i++) begin
      @(negedge clk);
      branch_jump_signal = 1'b1;
      if (i % 2 == 0) begin
        instruction          = random_instr(rv_isa_pkg::op_load);
        reg_write_address_ex = 5'($urandom_range(1, 31));
        instruction[19:15]   = reg_write_address_ex;  // forced hazard
        mem_read_ex          = 1'b1;
      end else begin
        instruction          = random_instr(pick_opcode($urandom_range(0, 8)));
        reg_write_address_ex = 5'($urandom_range(0, 31));
        mem_read_ex          = 1'($urandom_range(0, 1));
      end
    end
    report_test("branch flush", errs_before);
    branch_jump_signal = 1'b0;
    mem_read_ex        = 1'b0;
    check_en           = 1'b0;

    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/hazard_flush_unit.sv
`default_nettype none

module hazard_flush_unit (
  input  wire logic                               use_rs1,
  input  wire logic                               use_rs2,
  input  wire logic                               mem_read_ex,
  input  wire logic [rv_isa_pkg::reg_addr_w-1:0]  rd_ex,
  input  wire logic [rv_isa_pkg::reg_addr_w-1:0]  rs1,
  input  wire logic [rv_isa_pkg::reg_addr_w-1:0]  rs2,
  input  wire logic                               branch_jump_signal,
  output logic                                    hazard_detect_signal,
  output rv_ctrl_pkg::pipe_ctrl_t                 pipe_ctrl
);

  logic rs1_match;
  logic rs2_match;

  assign rs1_match = use_rs1 && (rd_ex == rs1);
  assign rs2_match = use_rs2 && (rd_ex == rs2);

  // load in execute feeding an operand needed now
  assign hazard_detect_signal = mem_read_ex && (rd_ex != '0) && (rs1_match || rs2_match);

  always_comb begin
    pipe_ctrl = '0;
    if (branch_jump_signal) begin
      // taken branch or jump drops both younger instructions
      pipe_ctrl.reset_if_reg = 1'b1;
      pipe_ctrl.reset_id_reg = 1'b1;
    end else if (hazard_detect_signal) begin
      pipe_ctrl.hold_if_reg  = 1'b1;  // keep fetch
      pipe_ctrl.reset_id_reg = 1'b1;  // bubble into execute
    end
  end

endmodule

`default_nettype wire

//--- rtl/imm_gen.sv
`default_nettype none

module imm_gen (
  input  wire logic [rv_isa_pkg::xlen-1:0]  instruction,
  input  rv_ctrl_pkg::imm_sel_e             imm_sel,
  output logic      [rv_isa_pkg::xlen-1:0]  imm
);

  logic [rv_isa_pkg::xlen-1:0] i_imm;
  logic [rv_isa_pkg::xlen-1:0] s_imm;
  logic [rv_isa_pkg::xlen-1:0] b_imm;
  logic [rv_isa_pkg::xlen-1:0] u_imm;
  logic [rv_isa_pkg::xlen-1:0] j_imm;

  assign i_imm = {{20{instruction[31]}}, instruction[31:20]};
  assign s_imm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
  assign b_imm = {{19{instruction[31]}}, instruction[31], instruction[7],
                  instruction[30:25], instruction[11:8], 1'b0};  // halfword offset
  assign u_imm = {instruction[31:12], 12'b0};
  assign j_imm = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                  instruction[20], instruction[30:21], 1'b0};

  always_comb begin
    case (imm_sel)
      rv_ctrl_pkg::imm_s: imm = s_imm;
      rv_ctrl_pkg::imm_b: imm = b_imm;
      rv_ctrl_pkg::imm_u: imm = u_imm;
      rv_ctrl_pkg::imm_j: imm = j_imm;
      default:            imm = i_imm;  // imm_i and unused codes
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/instruction_decode_unit.sv
`default_nettype none

module instruction_decode_unit (
  input  wire logic                               clk,
  input  wire logic                               reset,
  input  wire logic [rv_isa_pkg::xlen-1:0]        instruction,
  input  wire logic [rv_isa_pkg::xlen-1:0]        data_in,          // write-back data
  input  wire logic                               wb_write_en,
  input  wire logic [rv_isa_pkg::reg_addr_w-1:0]  wb_write_addr,
  input  wire logic                               mem_read_ex,      // load in execute
  input  wire logic [rv_isa_pkg::reg_addr_w-1:0]  reg_write_address_ex,
  input  wire logic                               branch_jump_signal,
  output rv_ctrl_pkg::ctrl_t                      ctrl,
  output logic      [2:0]                         fun_3,
  output logic                                    rotate_signal,
  output logic      [rv_isa_pkg::reg_addr_w-1:0]  write_address_for_current_instruction,
  output logic      [rv_isa_pkg::reg_addr_w-1:0]  reg_read_address_1,
  output logic      [rv_isa_pkg::reg_addr_w-1:0]  reg_read_address_2,
  output logic      [rv_isa_pkg::xlen-1:0]        data_1,
  output logic      [rv_isa_pkg::xlen-1:0]        data_2,
  output logic      [rv_isa_pkg::xlen-1:0]        imm,
  output logic                                    hazard_detect_signal,
  output rv_ctrl_pkg::pipe_ctrl_t                 pipe_ctrl
);

  // instruction fields
  assign write_address_for_current_instruction = instruction[11:7];
  assign reg_read_address_1 = instruction[19:15];
  assign reg_read_address_2 = instruction[24:20];
  assign fun_3              = instruction[14:12];
  assign rotate_signal      = instruction[30];  // sra / srai select

  main_control u_main_control (
    .opcode   (instruction[6:0]),
    .funct3   (instruction[14:12]),
    .funct7_5 (instruction[30]),
    .ctrl     (ctrl)
  );

  reg_file u_reg_file (
    .clk         (clk),
    .reset       (reset),
    .read_addr_1 (reg_read_address_1),
    .read_addr_2 (reg_read_address_2),
    .write_addr  (wb_write_addr),
    .write_en    (wb_write_en),
    .write_data  (data_in),
    .data_1      (data_1),
    .data_2      (data_2)
  );

  imm_gen u_imm_gen (
    .instruction (instruction),
    .imm_sel     (ctrl.imm_sel),
    .imm         (imm)
  );

  hazard_flush_unit u_hazard_flush_unit (
    .use_rs1              (ctrl.use_rs1),
    .use_rs2              (ctrl.use_rs2),
    .mem_read_ex          (mem_read_ex),
    .rd_ex                (reg_write_address_ex),
    .rs1                  (reg_read_address_1),
    .rs2                  (reg_read_address_2),
    .branch_jump_signal   (branch_jump_signal),
    .hazard_detect_signal (hazard_detect_signal),
    .pipe_ctrl            (pipe_ctrl)
  );

endmodule

`default_nettype wire

//--- rtl/main_control.sv
`default_nettype none

module main_control (
  input  wire logic [6:0]         opcode,
  input  wire logic [2:0]         funct3,
  input  wire logic               funct7_5,
  output rv_ctrl_pkg::ctrl_t      ctrl
);

  always_comb begin
    ctrl            = '0;
    ctrl.imm_sel    = rv_ctrl_pkg::imm_i;
    ctrl.result_sel = rv_ctrl_pkg::res_alu;
    ctrl.alu_op     = rv_ctrl_pkg::alu_add;

    case (rv_isa_pkg::opcode_e'(opcode))
      rv_isa_pkg::op_lui: begin
        ctrl.write_reg_en = 1'b1;
        ctrl.result_sel   = rv_ctrl_pkg::res_imm;  // rd = imm
        ctrl.imm_sel      = rv_ctrl_pkg::imm_u;
      end
      rv_isa_pkg::op_auipc: begin
        ctrl.write_reg_en = 1'b1;
        ctrl.alu_src_pc   = 1'b1;  // pc + imm
        ctrl.alu_src_imm  = 1'b1;
        ctrl.imm_sel      = rv_ctrl_pkg::imm_u;
      end
      rv_isa_pkg::op_jal: begin
        ctrl.jump         = 1'b1;
        ctrl.write_reg_en = 1'b1;
        ctrl.result_sel   = rv_ctrl_pkg::res_pc4;
        ctrl.alu_src_pc   = 1'b1;  // target pc + imm
        ctrl.alu_src_imm  = 1'b1;
        ctrl.imm_sel      = rv_ctrl_pkg::imm_j;
      end
      rv_isa_pkg::op_jalr: begin
        ctrl.jump         = 1'b1;
        ctrl.write_reg_en = 1'b1;
        ctrl.result_sel   = rv_ctrl_pkg::res_pc4;
        ctrl.use_rs1      = 1'b1;  // target rs1 + imm
        ctrl.alu_src_imm  = 1'b1;
      end
      rv_isa_pkg::op_branch: begin
        ctrl.branch     = 1'b1;
        ctrl.use_rs1    = 1'b1;
        ctrl.use_rs2    = 1'b1;
        ctrl.complement = 1'b1;  // compare by subtracting
        ctrl.imm_sel    = rv_ctrl_pkg::imm_b;
      end
      rv_isa_pkg::op_load: begin
        ctrl.d_mem_r      = 1'b1;
        ctrl.write_reg_en = 1'b1;
        ctrl.mem_to_reg   = 1'b1;
        ctrl.use_rs1      = 1'b1;
        ctrl.alu_src_imm  = 1'b1;
      end
      rv_isa_pkg::op_store: begin
        ctrl.d_mem_w     = 1'b1;
        ctrl.use_rs1     = 1'b1;
        ctrl.use_rs2     = 1'b1;  // store data
        ctrl.alu_src_imm = 1'b1;
        ctrl.imm_sel     = rv_ctrl_pkg::imm_s;
      end
      rv_isa_pkg::op_imm: begin
        ctrl.write_reg_en = 1'b1;
        ctrl.use_rs1      = 1'b1;
        ctrl.alu_src_imm  = 1'b1;
        ctrl.alu_op       = rv_ctrl_pkg::alu_op_e'(funct3);
      end
      rv_isa_pkg::op_reg: begin
        ctrl.write_reg_en = 1'b1;
        ctrl.use_rs1      = 1'b1;
        ctrl.use_rs2      = 1'b1;
        ctrl.alu_op       = rv_ctrl_pkg::alu_op_e'(funct3);
        ctrl.complement   = (funct3 == rv_isa_pkg::f3_add) && funct7_5;  // sub
      end
      default: begin
        // unknown opcode keeps the all-zero bundle so nothing is written
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`default_nettype none

module reg_file (
  input  wire logic                               clk,
  input  wire logic                               reset,
  input  wire logic [rv_isa_pkg::reg_addr_w-1:0]  read_addr_1,
  input  wire logic [rv_isa_pkg::reg_addr_w-1:0]  read_addr_2,
  input  wire logic [rv_isa_pkg::reg_addr_w-1:0]  write_addr,
  input  wire logic                               write_en,
  input  wire logic [rv_isa_pkg::xlen-1:0]        write_data,
  output logic      [rv_isa_pkg::xlen-1:0]        data_1,
  output logic      [rv_isa_pkg::xlen-1:0]        data_2
);

  logic [rv_isa_pkg::xlen-1:0] regs [rv_isa_pkg::num_regs];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < rv_isa_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && (write_addr != '0)) begin  // x0 is never written
      regs[write_addr] <= write_data;
    end
  end

  // no bypass so a write shows up after the edge
  always_comb begin
    if (read_addr_1 == '0) begin
      data_1 = '0;
    end else begin
      data_1 = regs[read_addr_1];
    end

    if (read_addr_2 == '0) begin
      data_2 = '0;
    end else begin
      data_2 = regs[read_addr_2];
    end
  end

endmodule

`default_nettype wire

//--- rtl/rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

  // alu operation coded like funct3
  typedef enum logic [2:0] {
    alu_add  = rv_isa_pkg::f3_add,
    alu_sll  = rv_isa_pkg::f3_sll,
    alu_slt  = rv_isa_pkg::f3_slt,
    alu_sltu = rv_isa_pkg::f3_sltu,
    alu_xor  = rv_isa_pkg::f3_xor,
    alu_sr   = rv_isa_pkg::f3_sr,
    alu_or   = rv_isa_pkg::f3_or,
    alu_and  = rv_isa_pkg::f3_and
  } alu_op_e;

  typedef enum logic [2:0] {
    imm_i = 3'd0,
    imm_s = 3'd1,
    imm_b = 3'd2,
    imm_u = 3'd3,
    imm_j = 3'd4
  } imm_sel_e;

  typedef enum logic [1:0] {
    res_alu = 2'd0,  // alu result
    res_imm = 2'd1,  // immediate straight through (lui)
    res_pc4 = 2'd2   // link address
  } result_sel_e;

  // control bundle handed to the later stages
  typedef struct packed {
    logic        d_mem_r;
    logic        d_mem_w;
    logic        branch;
    logic        jump;
    logic        write_reg_en;
    logic        mem_to_reg;    // load data instead of result
    result_sel_e result_sel;
    logic        use_rs1;       // operand a read from rs1
    logic        use_rs2;       // rs2 read by the instruction
    logic        alu_src_pc;    // operand a is pc
    logic        alu_src_imm;   // operand b is the immediate
    logic        complement;    // subtract
    imm_sel_e    imm_sel;
    alu_op_e     alu_op;
  } ctrl_t;

  // hold and flush levels for the front of the pipe
  typedef struct packed {
    logic hold_if_reg;
    logic reset_if_reg;
    logic reset_id_reg;
  } pipe_ctrl_t;

endpackage

`default_nettype wire

//--- rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  localparam int xlen       = 32;  // data path width
  localparam int reg_addr_w = 5;   // register index width
  localparam int num_regs   = 32;  // architectural registers

  localparam int opcode_w = 7;
  localparam int funct3_w = 3;

  // base opcodes of RV32I handled by this decode stage
  typedef enum logic [opcode_w-1:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011
  } opcode_e;

  // funct3 of the integer ALU group
  localparam logic [funct3_w-1:0] f3_add  = 3'b000;  // add / sub / addi
  localparam logic [funct3_w-1:0] f3_sll  = 3'b001;
  localparam logic [funct3_w-1:0] f3_slt  = 3'b010;
  localparam logic [funct3_w-1:0] f3_sltu = 3'b011;
  localparam logic [funct3_w-1:0] f3_xor  = 3'b100;
  localparam logic [funct3_w-1:0] f3_sr   = 3'b101;  // srl or sra by bit 30
  localparam logic [funct3_w-1:0] f3_or   = 3'b110;
  localparam logic [funct3_w-1:0] f3_and  = 3'b111;

endpackage

`default_nettype wire

//--- rv_decode.f
+incdir+include
rtl/rv_isa_pkg.sv
rtl/rv_ctrl_pkg.sv
rtl/main_control.sv
rtl/reg_file.sv
rtl/imm_gen.sv
rtl/hazard_flush_unit.sv
rtl/instruction_decode_unit.sv
bench/decode_tb.sv
